//--- logic/a_slot_decoder.sv
`timescale 1ns/10ps

`include "ctrl_consts.svh"

module a_slot_decoder (
    input  ctrl_pkg::slot_view_t       slot_view,
    input  logic [`CTRL_INSN_BITS-1:0] insn,
    output ctrl_pkg::a_ctrl_t          a_ctrl
);
    import ctrl_pkg::*;

    logic [`CTRL_OP_BITS-1:0] a_op;  // Opcode of the fetched instruction
    logic [1:0]               a_kind;

    assign a_op   = insn[`CTRL_INSN_BITS-1:`CTRL_INSN_OP_LSB];
    assign a_kind = a_op[`CTRL_OP_KIND_HI:`CTRL_OP_KIND_LO];

    always_comb begin
        a_ctrl         = '0;    // Muxes at source 0
        a_ctrl.en_d4   = 1'b1;
        a_ctrl.en_var3 = 1'b1;
        a_ctrl.en_op   = 1'b1;
        // Edit machine owns slot A on odd cycles
        a_ctrl.flag_b  = ~slot_view.tran_in_a;

        case (slot_view.a_state)
            SETUP: begin
                a_ctrl.mux_var = 2'd2;  // Next state with flag
            end
            STD: begin
                case (a_kind)
                    `CTRL_KIND_NXT: begin
                        // NXT1 jumps n+2 ahead
                        if (slot_view.tran_in_a && !a_op[`CTRL_OP_EX])
                            a_ctrl.mux_jc = 2'd3;
                    end
                    `CTRL_KIND_DO: begin
                        a_ctrl.mux_jc  = 2'd2;  // Fixed jump of 2
                        a_ctrl.mux_var = 2'd3;
                    end
                    default: ;
                endcase
            end
            T_NXT: begin
                a_ctrl.en_d4   = 1'b0;
                a_ctrl.mux_var = 2'd1;  // Nibble load
                a_ctrl.mux_jc  = 2'd2;
            end
            T_TRA: begin
                a_ctrl.mux_var = 2'd1;  // Nibble load
            end
            FINISH: begin
                // Var frozen until next setup
                a_ctrl.en_var3 = 1'b0;
                a_ctrl.en_d4   = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/b_slot_decoder.sv
`timescale 1ns/10ps

`include "ctrl_consts.svh"

module b_slot_decoder (
    input  ctrl_pkg::slot_view_t     slot_view,
    input  logic [`CTRL_OP_BITS-1:0] data_hi,
    output ctrl_pkg::b_ctrl_t        b_ctrl
);
    import ctrl_pkg::*;

    logic       ex;
    logic       fin;
    logic [1:0] kind;
    logic       tran_in_b;

    assign ex        = data_hi[`CTRL_OP_EX];
    assign fin       = data_hi[`CTRL_OP_FIN];
    assign kind      = data_hi[`CTRL_OP_KIND_HI:`CTRL_OP_KIND_LO];
    assign tran_in_b = ~slot_view.tran_in_a;

    always_comb begin
        b_ctrl       = '0;     // Nothing written and all muxes at 0
        b_ctrl.en_pc = 1'b1;   // PC advances unless told otherwise

        case (slot_view.b_state)
            SETUP: begin
                // Jump to the setup entry of the table
                b_ctrl.en_addr_lo = 1'b1;
                b_ctrl.mux_pc_a2  = 1'b1;
                b_ctrl.mux_offs   = 1'b1;  // Setup offset
            end
            INIT: begin
                // Full address plus transition offset
                b_ctrl.en_addr_hi = 1'b1;
                b_ctrl.en_addr_lo = 1'b1;
                b_ctrl.mux_pc_a2  = 1'b1;
            end
            STD: begin
                case (kind)
                    `CTRL_KIND_NXT: begin
                        if (tran_in_b) begin
                            b_ctrl.en_hi = 1'b1;
                            if (ex) begin
                                // NXT0 takes PC from stack slice
                                b_ctrl.mux_hi    = 1'b1;
                                b_ctrl.mux_pc_a1 = 1'b1;
                            end else begin
                                // NXT1 keeps return address below the table entry
                                b_ctrl.en_ra      = 1'b1;
                                b_ctrl.mux_ra     = 1'b1;
                                b_ctrl.mux_pc_a2  = 1'b1;
                                b_ctrl.en_addr_lo = 1'b1;
                            end
                        end else begin
                            // VIO pushes a LUT result
                            b_ctrl.en_push     = 1'b1;
                            b_ctrl.en_stack_wr = 1'b1;
                            b_ctrl.mux_sta     = 2'd2;
                        end
                    end
                    `CTRL_KIND_OP: begin
                        b_ctrl.en_pop      = 1'b1;  // Pop or push per var
                        b_ctrl.en_push     = 1'b1;
                        b_ctrl.en_stack_wr = 1'b1;
                        b_ctrl.mux_sta     = 2'd2;  // LUT
                    end
                    `CTRL_KIND_PSH: begin
                        b_ctrl.en_push_force = 1'b1;
                        b_ctrl.en_stack_wr   = 1'b1;  // Input value on top
                    end
                    default: begin
                        // DO calls with PC+1 as return
                        b_ctrl.en_ra = 1'b1;
                    end
                endcase
            end
            ACC, E_ACC: begin
                b_ctrl.en_stack_wr = 1'b1;
                b_ctrl.mux_sta     = 2'd3;  // Accumulator
            end
            T_NXT: begin
                // Same jump as NXT1
                b_ctrl.en_hi      = 1'b1;
                b_ctrl.en_ra      = 1'b1;
                b_ctrl.mux_ra     = 1'b1;
                b_ctrl.mux_pc_a2  = 1'b1;
                b_ctrl.en_addr_lo = 1'b1;
            end
            T_TRA: begin
                b_ctrl.en_next_state = 1'b1;  // Latch next state from var
            end
            T_RST: begin
                b_ctrl.en_clk_reset = 1'b1;
            end
            E_EDIT: begin
                b_ctrl.en_edit      = 1'b1;
                b_ctrl.mux_data     = 1'b1;  // Write the stack value out
                // Last edit of a group drops its operand
                b_ctrl.en_pop_force = ~(fin | ex);
            end
            FINISH: begin
                b_ctrl.en_pc = 1'b0;  // Hold until setup
            end
            default: ;
        endcase

        // Clock reset comes only from the transition machine in its B slot
        assert (!b_ctrl.en_clk_reset ||
                (slot_view.b_state == T_RST && !slot_view.tran_in_a))
            else $error("en_clk_reset outside transition T_RST");
    end

endmodule

//--- logic/controller_top.sv
`timescale 1ns/10ps

`include "ctrl_consts.svh"

module controller_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`CTRL_INSN_BITS-1:0] insn,        // A-slot instruction
    input  logic [`CTRL_OP_BITS-1:0]   data_hi,     // B-slot opcode from var
    input  logic [`CTRL_TICK_BITS-1:0] cfg_tick_len,
    input  logic [`CTRL_PROG_BITS-1:0] cfg_prog_len,
    output ctrl_pkg::a_ctrl_t          a_ctrl,
    output ctrl_pkg::b_ctrl_t          b_ctrl,
    output logic                       event_setup,
    output logic                       event_flush,
    output logic                       cycle,
    output ctrl_pkg::ctrl_state_e      db_es_tran,
    output ctrl_pkg::ctrl_state_e      db_es_edit
);
    import ctrl_pkg::*;

    logic       do_setup;   // Two-clock setup window
    slot_view_t slot_view;  // States seen by both decoders

    tick_timer u_timer (
        .clk          (clk),
        .reset        (reset),
        .cfg_tick_len (cfg_tick_len),
        .cfg_prog_len (cfg_prog_len),
        .event_setup  (event_setup),
        .event_flush  (event_flush),
        .do_setup     (do_setup)
    );

    slot_sequencer u_seq (
        .clk        (clk),
        .reset      (reset),
        .data_hi    (data_hi),
        .do_setup   (do_setup),
        .slot_view  (slot_view),
        .tran_state (db_es_tran),
        .edit_state (db_es_edit),
        .cycle      (cycle)
    );

    a_slot_decoder u_a_dec (
        .slot_view (slot_view),
        .insn      (insn),
        .a_ctrl    (a_ctrl)
    );

    b_slot_decoder u_b_dec (
        .slot_view (slot_view),
        .data_hi   (data_hi),
        .b_ctrl    (b_ctrl)
    );

endmodule

//--- logic/ctrl_consts.svh
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// Tick length width, tick counter gets one more bit for half-ticks
`define CTRL_TICK_BITS 16
`define CTRL_PROG_BITS 8   // Program length width

// Instruction word from program memory
`define CTRL_INSN_BITS 8
`define CTRL_OP_BITS 3     // Opcode width, A and B side alike
`define CTRL_INSN_OP_LSB (`CTRL_INSN_BITS - `CTRL_OP_BITS)

// Opcode fields
`define CTRL_OP_EX 0       // Extend bit
`define CTRL_OP_FIN 2      // Finish bit, only meaningful in E_EDIT
`define CTRL_OP_KIND_HI 2  // Top two bits pick the instruction kind
`define CTRL_OP_KIND_LO 1

// Instruction kinds
`define CTRL_KIND_NXT 2'b00  // NXT on transition side, VIO on edit side
`define CTRL_KIND_OP 2'b01
`define CTRL_KIND_PSH 2'b10
`define CTRL_KIND_DO 2'b11

`endif

//--- logic/ctrl_pkg.sv
package ctrl_pkg;

`include "ctrl_consts.svh"

    // Half-tick count, one bit wider than the tick length
    typedef logic [`CTRL_TICK_BITS:0] tick_cnt_t;

    // Machine state, top bits group the families
    typedef enum logic [7:0] {
        FINISH = 8'b0000_0000,
        SETUP  = 8'b0000_0001,
        INIT   = 8'b0000_0010,
        STD    = 8'b1000_0001,  // Shared by both machines
        ACC    = 8'b1000_0010,
        E_ACC  = 8'b0100_0010,  // Edit machine only
        E_EDIT = 8'b0100_0001,
        T_NXT  = 8'b1100_0000,  // Transition machine only
        T_TRA  = 8'b1100_0001,
        T_RST  = 8'b1100_0010
    } ctrl_state_e;

    // A-slot control word
    typedef struct packed {
        logic [1:0] mux_jc;   // Jump counter source
        logic [1:0] mux_var;  // Var source
        logic en_d4;          // Write var bit 4
        logic en_var3;        // Write var bits 3..0
        logic en_op;          // Write op register
        logic flag_b;
    } a_ctrl_t;

    // B-slot control word
    typedef struct packed {
        // Program flow
        logic en_pc;
        logic en_ra;
        logic en_addr_hi;
        logic en_addr_lo;
        logic mux_ra;         // 1 picks offset plus inverted var
        logic mux_pc_a1;      // 1 picks stack slice
        logic mux_pc_a2;      // 1 picks offset, else PC+1
        logic mux_offs;       // 1 picks setup table offset
        // Parsing
        logic mux_hi;
        logic en_hi;
        logic en_next_state;
        // Outputs and clock
        logic en_edit;
        logic mux_data;
        logic en_clk_reset;
        // Stack
        logic en_push_force;
        logic en_pop;
        logic en_pop_force;
        logic en_push;
        logic en_stack_wr;
        logic [1:0] mux_sta;  // Top of stack source
    } b_ctrl_t;

    // Both slot states plus which machine owns slot A
    typedef struct packed {
        ctrl_state_e a_state;
        ctrl_state_e b_state;
        logic tran_in_a;
    } slot_view_t;

endpackage

//--- logic/slot_sequencer.sv
`timescale 1ns/10ps

`include "ctrl_consts.svh"

module slot_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`CTRL_OP_BITS-1:0] data_hi,
    input  logic                     do_setup,
    output ctrl_pkg::slot_view_t     slot_view,
    output ctrl_pkg::ctrl_state_e    tran_state,
    output ctrl_pkg::ctrl_state_e    edit_state,
    output logic                     cycle
);
    import ctrl_pkg::*;

    ctrl_state_e tran_q;     // Transition machine state
    ctrl_state_e edit_q;     // Edit machine state
    ctrl_state_e a_state;
    ctrl_state_e b_state;
    ctrl_state_e next_b;     // Next state for the B-slot machine
    logic        cycle_q;
    logic        tran_in_b;
    logic        ex;
    logic        fin;
    logic [1:0]  kind;

    // Even cycle puts the transition machine in slot A
    assign tran_in_b = cycle_q;
    assign a_state   = tran_in_b ? edit_q : tran_q;
    assign b_state   = tran_in_b ? tran_q : edit_q;

    assign ex   = data_hi[`CTRL_OP_EX];
    assign fin  = data_hi[`CTRL_OP_FIN];
    assign kind = data_hi[`CTRL_OP_KIND_HI:`CTRL_OP_KIND_LO];

    always_comb begin
        case (b_state)
            SETUP: next_b = INIT;
            INIT:  next_b = STD;
            STD: begin
                case (kind)
                    `CTRL_KIND_NXT: begin
                        if (tran_in_b)
                            next_b = ex ? T_NXT : T_TRA;  // NXT0 or NXT1
                        else
                            next_b = ex ? E_ACC : E_EDIT;  // VIO
                    end
                    `CTRL_KIND_OP,
                    `CTRL_KIND_PSH: next_b = ex ? ACC : STD;
                    default:        next_b = STD;  // DO
                endcase
            end
            ACC:    next_b = ex ? ACC : STD;      // Accumulate chain
            E_ACC:  next_b = ex ? E_ACC : E_EDIT;
            T_NXT:  next_b = T_RST;
            T_RST:  next_b = T_TRA;
            T_TRA:  next_b = FINISH;
            E_EDIT: begin
                if (fin)
                    next_b = FINISH;
                else if (ex)
                    next_b = E_EDIT;  // More edits follow
                else
                    next_b = STD;
            end
            FINISH:  next_b = do_setup ? SETUP : FINISH;
            default: next_b = FINISH;  // Unknown code parks the machine
        endcase
    end

    // Only the B-slot machine moves, parity flips every clock
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tran_q  <= FINISH;
            edit_q  <= FINISH;
            cycle_q <= 1'b0;
        end else begin
            if (tran_in_b)
                tran_q <= next_b;
            else
                edit_q <= next_b;
            cycle_q <= ~cycle_q;
        end
    end

    assign slot_view = '{a_state: a_state, b_state: b_state, tran_in_a: ~cycle_q};

    assign tran_state = tran_q;
    assign edit_state = edit_q;
    assign cycle      = cycle_q;

    // A machine in slot A keeps its state over the edge
    assert property (@(posedge clk) disable iff (reset) !cycle_q |=> $stable(tran_q))
        else $error("transition state moved while in slot A");
    assert property (@(posedge clk) disable iff (reset) cycle_q |=> $stable(edit_q))
        else $error("edit state moved while in slot A");

endmodule

//--- logic/tick_timer.sv
`timescale 1ns/10ps

`include "ctrl_consts.svh"

module tick_timer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`CTRL_TICK_BITS-1:0] cfg_tick_len,
    input  logic [`CTRL_PROG_BITS-1:0] cfg_prog_len,
    output logic                       event_setup,
    output logic                       event_flush,
    output logic                       do_setup
);
    import ctrl_pkg::*;

    tick_cnt_t count;        // Counts half-ticks
    tick_cnt_t last_count;   // Final half-tick of the period
    tick_cnt_t flush_count;
    logic      final_tick;
    logic      setup_d;      // Setup pulse delayed by one clock

    // Two clocks per tick, so the last value is 2*len+1
    assign last_count  = {cfg_tick_len, 1'b1};
    assign flush_count = tick_cnt_t'({cfg_prog_len, 1'b1}); // Zero extended
    assign final_tick  = count == last_count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (final_tick) begin
            count <= '0;  // Wrap
        end else begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            setup_d <= 1'b0;
        else
            setup_d <= event_setup;
    end

    assign event_setup = count == '0;
    assign event_flush = count == flush_count;
    // Stretched over two clocks so each machine meets it in a B slot
    assign do_setup    = event_setup | setup_d;

    // Period is at least two clocks
    assert property (@(posedge clk) disable iff (reset) event_setup |=> !event_setup)
        else $error("event_setup high in two consecutive cycles");

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module controller_tb

out=$(./obj_dir/Vcontroller_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^Testbench passed$"; then
    exit 0
else
    exit 1
fi

//--- src.f
+incdir+logic
logic/ctrl_pkg.sv
logic/tick_timer.sv
logic/slot_sequencer.sv
logic/a_slot_decoder.sv
logic/b_slot_decoder.sv
logic/controller_top.sv
verif/controller_tb.sv

//--- verif/controller_tb.sv
`timescale 1ns/10ps

`include "ctrl_consts.svh"

module controller_tb;
    import ctrl_pkg::*;

    localparam int WAIT_LIMIT = 200;                   // Cycles allowed per wait
    localparam int TICK_LEN   = 20;
    localparam int PROG_LEN   = 6;
    localparam int PERIOD     = 2 * (TICK_LEN + 1);    // Clocks per tick period
    localparam int FLUSH_AT   = 2 * PROG_LEN + 1;      // Flush offset after setup

    logic                       clk;
    logic                       reset;
    logic [`CTRL_INSN_BITS-1:0] insn;
    logic [`CTRL_OP_BITS-1:0]   data_hi;
    logic [`CTRL_TICK_BITS-1:0] cfg_tick_len;
    logic [`CTRL_PROG_BITS-1:0] cfg_prog_len;
    a_ctrl_t                    a_ctrl;
    b_ctrl_t                    b_ctrl;
    logic                       event_setup;
    logic                       event_flush;
    logic                       cycle;
    ctrl_state_e                db_es_tran;
    ctrl_state_e                db_es_edit;

    // Reference model state
    int          model_count;   // Expected tick count
    ctrl_state_e model_tran;
    ctrl_state_e model_edit;
    logic        model_cycle;   // Expected parity
    logic        past_ok;       // One clock seen since reset
    logic [31:0] rnd_state;
    ctrl_state_e a_slot_state;
    ctrl_state_e b_slot_state;

    controller_top dut (
        .clk          (clk),
        .reset        (reset),
        .insn         (insn),
        .data_hi      (data_hi),
        .cfg_tick_len (cfg_tick_len),
        .cfg_prog_len (cfg_prog_len),
        .a_ctrl       (a_ctrl),
        .b_ctrl       (b_ctrl),
        .event_setup  (event_setup),
        .event_flush  (event_flush),
        .cycle        (cycle),
        .db_es_tran   (db_es_tran),
        .db_es_edit   (db_es_edit)
    );

    always #5 clk = ~clk;

    // Parity 0 puts the transition machine in slot A
    assign a_slot_state = cycle ? db_es_edit : db_es_tran;
    assign b_slot_state = cycle ? db_es_tran : db_es_edit;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Next state of the B-slot machine as the sequencing rules give it
    function automatic ctrl_state_e expected_next(input ctrl_state_e s, input logic tran_side,
                                                  input logic [2:0] op, input logic setup_win);
        ctrl_state_e n;
        n = s;
        case (s)
            SETUP: n = INIT;
            INIT:  n = STD;
            STD: begin
                if (op[2:1] == 2'b00) begin
                    if (tran_side)
                        n = op[0] ? T_NXT : T_TRA;
                    else
                        n = op[0] ? E_ACC : E_EDIT;
                end else if (op[2:1] != 2'b11 && op[0]) begin
                    n = ACC;  // OP or PSH with ex
                end
            end
            ACC:     n = op[0] ? ACC : STD;
            E_ACC:   n = op[0] ? E_ACC : E_EDIT;
            T_NXT:   n = T_RST;
            T_RST:   n = T_TRA;
            T_TRA:   n = FINISH;
            E_EDIT:  n = op[2] ? FINISH : (op[0] ? E_EDIT : STD);
            FINISH:  n = setup_win ? SETUP : FINISH;
            default: n = FINISH;
        endcase
        return n;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            model_count <= 0;
            model_tran  <= FINISH;
            model_edit  <= FINISH;
            model_cycle <= 1'b0;
            past_ok     <= 1'b0;
        end else begin
            model_count <= (model_count == PERIOD - 1) ? 0 : model_count + 1;
            model_cycle <= ~model_cycle;
            past_ok     <= 1'b1;
            // Setup window covers counts 0 and 1
            if (model_cycle)
                model_tran <= expected_next(model_tran, 1'b1, data_hi, model_count <= 1);
            else
                model_edit <= expected_next(model_edit, 1'b0, data_hi, model_count <= 1);
        end
    end

    task automatic value_error(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("error %s expected %0h actual %0h", test, expected, actual);
        $display("Testbench failed");
        $fatal(1, "value check failed");
    endtask

    task automatic check_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "check failed");
    endtask

    // Polls on falling edges until the chosen machine reaches target
    task automatic await_state(input logic tran_side, input ctrl_state_e target,
                               input string what);
        int n;
        n = 0;
        while ((tran_side ? db_es_tran : db_es_edit) != target && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if ((tran_side ? db_es_tran : db_es_edit) != target)
            check_failure($sformatf("timeout waiting for %s", what));
    endtask

    assert property (@(posedge clk) disable iff (reset) event_setup == (model_count == 0))
        else value_error("setup_event", $sampled(model_count == 0), $sampled(event_setup));
    assert property (@(posedge clk) disable iff (reset)
                     event_flush == (model_count == FLUSH_AT))
        else value_error("flush_event", $sampled(model_count == FLUSH_AT),
                         $sampled(event_flush));
    assert property (@(posedge clk) disable iff (reset) cycle == model_cycle)
        else value_error("cycle_parity", $sampled(model_cycle), $sampled(cycle));
    // Each machine only moves out of its B slot
    assert property (@(posedge clk) disable iff (reset)
                     past_ok && db_es_tran != $past(db_es_tran) |-> $past(cycle))
        else check_failure("transition state changed on an edit B-slot edge");
    assert property (@(posedge clk) disable iff (reset)
                     past_ok && db_es_edit != $past(db_es_edit) |-> !$past(cycle))
        else check_failure("edit state changed on a transition B-slot edge");
    assert property (@(posedge clk) disable iff (reset) db_es_tran == model_tran)
        else value_error("tran_state", $sampled(model_tran), $sampled(db_es_tran));
    assert property (@(posedge clk) disable iff (reset) db_es_edit == model_edit)
        else value_error("edit_state", $sampled(model_edit), $sampled(db_es_edit));
    assert property (@(posedge clk) disable iff (reset) a_slot_state == SETUP |->
                     a_ctrl.mux_var == 2'd2)
        else value_error("setup_mux_var", 2, $sampled(a_ctrl.mux_var));
    assert property (@(posedge clk) disable iff (reset) a_ctrl.flag_b == cycle)
        else value_error("flag_b", $sampled(cycle), $sampled(a_ctrl.flag_b));
    assert property (@(posedge clk) disable iff (reset)
                     b_ctrl.en_clk_reset == (cycle && db_es_tran == T_RST))
        else value_error("clk_reset", $sampled(cycle && db_es_tran == T_RST),
                         $sampled(b_ctrl.en_clk_reset));
    assert property (@(posedge clk) disable iff (reset)
                     !cycle && db_es_edit == E_EDIT |-> b_ctrl.en_edit)
        else value_error("edit_enable", 1, $sampled(b_ctrl.en_edit));
    assert property (@(posedge clk) disable iff (reset) !cycle && db_es_edit == E_EDIT |->
                     b_ctrl.en_pop_force == !(data_hi[2] || data_hi[0]))
        else value_error("pop_force", $sampled(!(data_hi[2] || data_hi[0])),
                         $sampled(b_ctrl.en_pop_force));
    assert property (@(posedge clk) disable iff (reset) b_slot_state == FINISH |-> !b_ctrl.en_pc)
        else value_error("finish_pc_hold", 0, $sampled(b_ctrl.en_pc));

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        insn         = '0;
        data_hi      = '0;
        cfg_tick_len = TICK_LEN;
        cfg_prog_len = PROG_LEN;
        rnd_state    = 32'd23;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Free run over several tick periods
        for (int i = 0; i < 400; i++) begin
            @(negedge clk);
            rnd_state = xorshift32(rnd_state);
            data_hi   = rnd_state[2:0];
            insn      = rnd_state[15:8];
        end

        @(negedge clk);
        data_hi = 3'b010;  // OP kind without ex, parks both in STD
        await_state(1'b1, STD, "transition machine in STD");
        await_state(1'b0, STD, "edit machine in STD");

        // Transition path NXT0
        data_hi = 3'b001;
        await_state(1'b1, T_NXT, "transition T_NXT");
        await_state(1'b1, T_RST, "transition T_RST");
        await_state(1'b1, T_TRA, "transition T_TRA");
        await_state(1'b1, FINISH, "transition FINISH");

        // Edit machine sits in E_ACC here
        data_hi = 3'b000;
        await_state(1'b0, E_EDIT, "edit E_EDIT after E_ACC");
        data_hi = 3'b001;  // Ex holds E_EDIT
        repeat (4) @(negedge clk);
        data_hi = 3'b000;
        await_state(1'b0, STD, "edit back to STD");
        await_state(1'b0, E_EDIT, "edit E_EDIT from STD");
        await_state(1'b0, STD, "edit STD again");
        data_hi = 3'b001;
        await_state(1'b0, E_ACC, "edit E_ACC from STD");
        data_hi = 3'b000;
        await_state(1'b0, E_EDIT, "edit E_EDIT before finish");
        data_hi = 3'b101;  // Finish bit
        await_state(1'b0, FINISH, "edit FINISH");

        // Both restart on the next setup
        data_hi = 3'b010;
        await_state(1'b1, STD, "transition restart");
        await_state(1'b0, STD, "edit restart");
        repeat (PERIOD) @(negedge clk);

        $display("Testbench passed");
        $finish;
    end

endmodule
